/* main_pkg.sv */
package main_pkg;

    // Mapper regions, one bit each in the active vector
    typedef enum logic [2:0] {
        REG_MEM = 3'd0,
        REG_SCR = 3'd1,
        REG_PAL = 3'd2,
        REG_OBJ = 3'd3,
        REG_IO  = 3'd4,
        REG_SUB = 3'd5
    } region_e;

    typedef enum logic [1:0] {
        GAME_OUTRUN  = 2'd0,
        GAME_SHANGON = 2'd1
    } game_e;

    typedef enum logic [2:0] {
        CTRL_DUAL_STICK = 3'd0,
        CTRL_TRIGGER    = 3'd1,
        CTRL_WHEEL      = 3'd2
    } ctrl_type_e;

    // ADC multiplexer channel
    typedef enum logic [2:0] {
        ADC_WHEEL = 3'd0,
        ADC_GAS   = 3'd1,
        ADC_BRAKE = 3'd2,
        ADC_MOTOR = 3'd3
    } adc_ch_e;

    // Main CPU bus as seen after the mapper
    typedef struct packed {
        logic [23:1] addr;     // Word address
        logic        as_n;
        logic        rnw;
        logic [1:0]  dsn;      // {UDS, LDS}, active low
        logic [2:0]  fc;
        logic [15:0] dout;     // CPU write data
    } cpu_bus_t;

    typedef struct packed {
        logic rom;
        logic ram;
        logic sub;
        logic chr;
        logic vram;
        logic objram;
        logic pal;
        logic io;
    } chip_sel_t;

    // Cabinet inputs, joystick bits active low
    typedef struct packed {
        logic [7:0]  joystick1;
        logic [15:0] joyana1;
        logic [15:0] joyana1b;
        logic [1:0]  start_button;
        logic [1:0]  coin_input;
        logic        service;
        logic        dip_test;
        logic [7:0]  dipsw_a;
        logic [7:0]  dipsw_b;
        ctrl_type_e  ctrl_type;
    } cab_in_t;

    localparam logic [2:0]  IACK_FC  = 3'd7;
    localparam logic [1:0]  RAM_BANK = 2'd3;      // Work RAM at $60000
    localparam logic [15:0] OPEN_BUS = 16'hffff;
    localparam logic [7:0]  IO_IDLE  = 8'hff;

    // Digital override values for wheel and pedals
    localparam logic [7:0] WHEEL_LEFT_OR   = 8'he0;
    localparam logic [7:0] WHEEL_RIGHT_OR  = 8'h20;
    localparam logic [7:0] WHEEL_LEFT_SHO  = 8'h20;
    localparam logic [7:0] WHEEL_RIGHT_SHO = 8'hd0;
    localparam logic [7:0] PEDAL_FULL      = 8'hff;
    localparam logic [7:0] PEDAL_FULL_SHO  = 8'hf0;

    localparam logic [7:0] ADC_SIGN_FLIP   = 8'h80; // Signed wheel to offset binary

endpackage

/* mem_decoder.sv */
`timescale 1ns/100ps

module mem_decoder (
    input  logic                clk,
    input  logic                rst,
    input  main_pkg::cpu_bus_t  bus,
    input  logic [7:0]          active,
    output main_pkg::chip_sel_t sel
);
    import main_pkg::*;

    chip_sel_t sel_nxt;
    logic      bus_ok;
    logic      any_ds;
    logic      ram_bank;
    logic      scr_hi;

    // Interrupt acknowledge cycles never reach memory
    assign bus_ok   = !bus.as_n && (bus.fc != IACK_FC);
    assign any_ds   = !(&bus.dsn);                // Strobes are active low
    assign ram_bank = (bus.addr[18:17] == RAM_BANK);
    assign scr_hi   = bus.addr[16];               // Character RAM half of scroll region

    always_comb begin
        sel_nxt = '0;
        if (bus_ok) begin
            // ROM and work RAM share the memory region
            sel_nxt.rom    = active[REG_MEM] && !ram_bank;
            sel_nxt.ram    = active[REG_MEM] && ram_bank && any_ds;

            sel_nxt.chr    = active[REG_SCR] && scr_hi;
            sel_nxt.vram   = active[REG_SCR] && !scr_hi && any_ds;

            sel_nxt.objram = active[REG_OBJ];
            sel_nxt.pal    = active[REG_PAL];
            sel_nxt.io     = active[REG_IO];
            sel_nxt.sub    = active[REG_SUB];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= '0;
        end else begin
            sel <= sel_nxt;
        end
    end

endmodule

/* cabinet_io.sv */
`timescale 1ns/100ps

module cabinet_io (
    input  logic               clk,
    input  logic               rst,
    input  logic               io_cs,
    input  main_pkg::cpu_bus_t bus,
    input  main_pkg::game_e    game_id,
    input  main_pkg::cab_in_t  cab,
    output logic [7:0]         cab_dout,
    output logic               video_en,
    output logic               snd_rstb,
    output logic               obj_toggle,
    output logic [1:0]         obj_cfg
);
    import main_pkg::*;

    adc_ch_e     adc_ch;
    logic [7:0]  dacana1;     // Captured wheel channel
    logic [15:0] dacana1b;    // Captured pedal channel
    logic        sho_game;
    logic        or_cs;
    logic        sho_cs;
    logic [2:0]  sho_code;
    logic        lo_wr;
    logic        ppic_wr;
    logic        adc_wr;
    logic [7:0]  pedal;
    logic [7:0]  gas_raw;
    logic [7:0]  brake_raw;
    logic [7:0]  wheel_left;
    logic [7:0]  wheel_right;
    logic [7:0]  pedal_full;
    logic        gas_key;
    logic        brake_key;
    logic [7:0]  adc_dout;

    assign sho_game = (game_id == GAME_SHANGON);
    assign or_cs    = io_cs && (game_id == GAME_OUTRUN);
    assign sho_cs   = io_cs && sho_game;
    assign sho_code = {bus.addr[13:12], bus.addr[5]}; // Hang On page select
    assign lo_wr    = !bus.rnw && !bus.dsn[0];

    // Port C of the former PPI
    assign ppic_wr = or_cs && (bus.addr[6:4] == 3'd0) && (bus.addr[2:1] == 2'd2) && lo_wr;

    // Per-game override values
    assign wheel_left  = sho_game ? WHEEL_LEFT_SHO  : WHEEL_LEFT_OR;
    assign wheel_right = sho_game ? WHEEL_RIGHT_SHO : WHEEL_RIGHT_OR;
    assign pedal_full  = sho_game ? PEDAL_FULL_SHO  : PEDAL_FULL;
    assign gas_key     = sho_game ? cab.joystick1[3] : cab.joystick1[4];
    assign brake_key   = sho_game ? cab.joystick1[2] : cab.joystick1[5];

    // Pedal conversion from the analog stick value
    always_comb begin
        pedal     = {dacana1b[14:8], dacana1b[14]};
        gas_raw   = dacana1b[15] ? ~pedal : 8'd0;
        brake_raw = dacana1b[15] ? 8'd0 : pedal;
        if (cab.ctrl_type == CTRL_TRIGGER) begin
            gas_raw = dacana1b[7] ? 8'd0 : {dacana1b[6:0], dacana1b[6]};
        end
    end

    always_comb begin
        case (adc_ch)
            ADC_WHEEL: begin
                if (!cab.joystick1[0])
                    adc_dout = wheel_left;
                else if (!cab.joystick1[1])
                    adc_dout = wheel_right;
                else
                    adc_dout = dacana1 ^ ADC_SIGN_FLIP;
            end
            ADC_GAS:   adc_dout = !gas_key ? pedal_full : gas_raw;
            ADC_BRAKE: adc_dout = !brake_key ? pedal_full : brake_raw;
            ADC_MOTOR: adc_dout = IO_IDLE;   // No motor fitted
            default:   adc_dout = IO_IDLE;
        endcase
    end

    // Read data, object strobe and ADC capture request
    always_comb begin
        cab_dout   = IO_IDLE;
        obj_toggle = 1'b0;
        adc_wr     = 1'b0;
        if (or_cs) begin
            case (bus.addr[6:4])
                3'd1: begin
                    case (bus.addr[2:1])
                        2'd0: cab_dout = {cab.coin_input, ~cab.joystick1[7], cab.joystick1[6],
                                          cab.start_button[0], cab.service, cab.dip_test, 1'b1};
                        2'd2: cab_dout = cab.dipsw_a;
                        2'd3: cab_dout = cab.dipsw_b;
                        default: cab_dout = IO_IDLE;
                    endcase
                end
                3'd3: begin
                    cab_dout = adc_dout;
                    adc_wr   = !bus.rnw;
                end
                3'd7: obj_toggle = 1'b1;
                default: ;
            endcase
        end
        if (sho_cs) begin
            case (sho_code)
                3'd2: begin
                    case (bus.addr[2:1])
                        2'd1: cab_dout = {2'b11, cab.joystick1[4], cab.start_button[0],
                                          cab.service, cab.dip_test, cab.coin_input};
                        2'd2: cab_dout = cab.dipsw_a;
                        2'd3: cab_dout = cab.dipsw_b;
                        default: cab_dout = IO_IDLE;
                    endcase
                end
                3'd7: begin
                    cab_dout = adc_dout;
                    adc_wr   = !bus.rnw;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            obj_cfg  <= 2'd0;
            video_en <= 1'b1;
            adc_ch   <= ADC_WHEEL;
            snd_rstb <= 1'b1;
        end else if (ppic_wr) begin
            obj_cfg  <= bus.dout[7:6];  // Object engine and colour mixer
            video_en <= bus.dout[5];
            adc_ch   <= adc_ch_e'(bus.dout[4:2]);
            snd_rstb <= bus.dout[0];
        end else if (sho_cs && lo_wr) begin
            case (sho_code)
                3'd0: begin
                    adc_ch   <= adc_ch_e'({1'b0, bus.dout[7:6]});
                    video_en <= bus.dout[4];
                end
                3'd1: snd_rstb <= ~bus.dout[0];
                default: ;
            endcase
        end
    end

    // Sample both analog inputs on an ADC write
    always_ff @(posedge clk) begin
        if (adc_wr) begin
            dacana1  <= cab.joyana1[7:0];
            dacana1b <= cab.joyana1b;
        end
    end

endmodule

/* read_data_mux.sv */
`timescale 1ns/100ps

module read_data_mux (
    input  logic                clk,
    input  logic                rst,
    input  main_pkg::chip_sel_t sel,
    input  logic [7:0]          cab_dout,
    input  logic [15:0]         rom_data,
    input  logic [15:0]         ram_data,
    input  logic [15:0]         char_dout,
    input  logic [15:0]         pal_dout,
    input  logic [15:0]         obj_dout,
    input  logic [15:0]         sub_din,
    input  logic                rom_ok,
    input  logic                ram_ok,
    input  logic                sub_ok,
    output logic [15:0]         cpu_din,
    output logic                bus_busy
);
    import main_pkg::*;

    logic [15:0] rd_word;
    logic        ram_any;

    assign ram_any = sel.ram || sel.vram;  // Both served by the RAM port

    // Read word by fixed priority
    always_comb begin
        if (ram_any)
            rd_word = ram_data;
        else if (sel.rom)
            rd_word = rom_data;            // Unencrypted ROM
        else if (sel.chr)
            rd_word = char_dout;
        else if (sel.pal)
            rd_word = pal_dout;
        else if (sel.objram)
            rd_word = obj_dout;
        else if (sel.sub)
            rd_word = sub_din;
        else if (sel.io)
            rd_word = {IO_IDLE, cab_dout}; // Byte-wide I/O
        else
            rd_word = OPEN_BUS;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= 16'd0;
        end else begin
            cpu_din <= rd_word;
        end
    end

    // Mapper stretches the cycle while data is pending
    assign bus_busy = (sel.rom && !rom_ok) ||
                      (ram_any && !ram_ok) ||
                      (sel.sub && !sub_ok);

endmodule

/* main_bus.sv */
`timescale 1ns/100ps

module main_bus (
    input  logic                clk,
    input  logic                rst,
    input  main_pkg::cpu_bus_t  bus,
    input  logic [7:0]          active,
    input  main_pkg::game_e     game_id,
    input  main_pkg::cab_in_t   cab,
    input  logic [15:0]         rom_data,
    input  logic [15:0]         ram_data,
    input  logic [15:0]         char_dout,
    input  logic [15:0]         pal_dout,
    input  logic [15:0]         obj_dout,
    input  logic [15:0]         sub_din,
    input  logic                rom_ok,
    input  logic                ram_ok,
    input  logic                sub_ok,
    output main_pkg::chip_sel_t sel,
    output logic [15:0]         cpu_din,
    output logic                bus_busy,
    output logic                video_en,
    output logic [1:0]          obj_cfg,
    output logic                snd_rstb,
    output logic                obj_toggle
);

    logic [7:0] cab_dout;   // Cabinet page read byte

    // Chip selects, one clock after the bus
    mem_decoder u_decoder (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .bus    ( bus    ),
        .active ( active ),
        .sel    ( sel    )
    );

    cabinet_io u_cabinet (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .io_cs      ( sel.io     ),
        .bus        ( bus        ),
        .game_id    ( game_id    ),
        .cab        ( cab        ),
        .cab_dout   ( cab_dout   ),
        .video_en   ( video_en   ),
        .snd_rstb   ( snd_rstb   ),
        .obj_toggle ( obj_toggle ),
        .obj_cfg    ( obj_cfg    )
    );

    // Read data to the CPU
    read_data_mux u_rd_mux (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .sel       ( sel       ),
        .cab_dout  ( cab_dout  ),
        .rom_data  ( rom_data  ),
        .ram_data  ( ram_data  ),
        .char_dout ( char_dout ),
        .pal_dout  ( pal_dout  ),
        .obj_dout  ( obj_dout  ),
        .sub_din   ( sub_din   ),
        .rom_ok    ( rom_ok    ),
        .ram_ok    ( ram_ok    ),
        .sub_ok    ( sub_ok    ),
        .cpu_din   ( cpu_din   ),
        .bus_busy  ( bus_busy  )
    );

endmodule

/* tb_main_bus.sv */
`timescale 1ns/100ps

module tb_main_bus;
    import main_pkg::*;

    logic        clk;
    logic        rst;
    cpu_bus_t    bus;
    logic [7:0]  active;
    game_e       game_id;
    cab_in_t     cab;
    logic [15:0] rom_data;
    logic [15:0] ram_data;
    logic [15:0] char_dout;
    logic [15:0] pal_dout;
    logic [15:0] obj_dout;
    logic [15:0] sub_din;
    logic        rom_ok;
    logic        ram_ok;
    logic        sub_ok;
    chip_sel_t   sel;
    logic [15:0] cpu_din;
    logic        bus_busy;
    logic        video_en;
    logic [1:0]  obj_cfg;
    logic        snd_rstb;
    logic        obj_toggle;

    int          checks;
    int          errors;
    int          test_errs;
    logic [31:0] rng_state;
    logic [15:0] s_din;       // Outputs sampled at the end of an access
    chip_sel_t   s_sel;
    logic        s_busy;
    logic        s_toggle;

    main_bus UUT (
        .clk(clk), .rst(rst), .bus(bus), .active(active), .game_id(game_id), .cab(cab),
        .rom_data(rom_data), .ram_data(ram_data), .char_dout(char_dout),
        .pal_dout(pal_dout), .obj_dout(obj_dout), .sub_din(sub_din),
        .rom_ok(rom_ok), .ram_ok(ram_ok), .sub_ok(sub_ok), .sel(sel), .cpu_din(cpu_din),
        .bus_busy(bus_busy), .video_en(video_en), .obj_cfg(obj_cfg),
        .snd_rstb(snd_rstb), .obj_toggle(obj_toggle)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [15:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[31:16];
    endfunction

    function automatic cpu_bus_t idle_bus();
        cpu_bus_t b;
        b      = '0;
        b.as_n = 1'b1;
        b.rnw  = 1'b1;    // Never a write while idle
        b.dsn  = 2'b11;
        return b;
    endfunction

    function automatic cpu_bus_t make_bus(logic [23:0] byte_addr, logic rnw, logic [1:0] dsn,
                                          logic [2:0] fc, logic [15:0] dout);
        cpu_bus_t b;
        b.addr = byte_addr[23:1];
        b.as_n = 1'b0;
        b.rnw  = rnw;
        b.dsn  = dsn;
        b.fc   = fc;
        b.dout = dout;
        return b;
    endfunction

    // Expected selects for one region and bus condition
    function automatic chip_sel_t expect_sel(logic [2:0] r, logic bank3, logic hi, logic ds,
                                             logic iack);
        chip_sel_t e;
        e = '0;
        if (!iack) begin
            case (r)
                REG_MEM: begin
                    e.rom = !bank3;
                    e.ram = bank3 && ds;
                end
                REG_SCR: begin
                    e.chr  = hi;
                    e.vram = !hi && ds;
                end
                REG_PAL: e.pal = 1'b1;
                REG_OBJ: e.objram = 1'b1;
                REG_IO:  e.io = 1'b1;
                REG_SUB: e.sub = 1'b1;
                default: e = '0;
            endcase
        end
        return e;
    endfunction

    // ADC byte from the captured analog words and the digital keys
    function automatic logic [7:0] adc_expect(logic sho, logic trig, logic [1:0] ch,
                                              logic [7:0] joy, logic [15:0] a1, logic [15:0] a1b);
        logic [7:0] hi;
        logic [7:0] lo;
        logic [7:0] pedal;
        logic [7:0] gas;
        logic [7:0] brake;
        logic [7:0] full;
        logic [7:0] res;
        hi    = a1b[15:8];
        lo    = a1b[7:0];
        pedal = {hi[6:0], hi[6]};
        gas   = hi[7] ? ~pedal : 8'h00;
        brake = hi[7] ? 8'h00 : pedal;
        if (trig)
            gas = lo[7] ? 8'h00 : {lo[6:0], lo[6]};   // Trigger uses the low byte
        full = sho ? PEDAL_FULL_SHO : PEDAL_FULL;
        case (ch)
            2'd0: begin
                if (!joy[0])
                    res = sho ? WHEEL_LEFT_SHO : WHEEL_LEFT_OR;
                else if (!joy[1])
                    res = sho ? WHEEL_RIGHT_SHO : WHEEL_RIGHT_OR;
                else
                    res = a1[7:0] ^ ADC_SIGN_FLIP;
            end
            2'd1: res = !(sho ? joy[3] : joy[4]) ? full : gas;
            2'd2: res = !(sho ? joy[2] : joy[5]) ? full : brake;
            default: res = IO_IDLE;                 // Motor channel
        endcase
        return res;
    endfunction

    task automatic compare_val(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            test_errs++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s done, %0d errors", name, test_errs);
        test_errs = 0;
    endtask

    task automatic release_bus();
        @(posedge clk);
        bus    <= idle_bus();
        active <= 8'h00;
        repeat (2) @(posedge clk);   // Selects and read data back to idle
    endtask

    // Hold one bus cycle for four clocks, then sample the outputs
    task automatic bus_access(input cpu_bus_t b, input logic [7:0] act);
        @(posedge clk);
        bus    <= b;
        active <= act;
        repeat (4) @(posedge clk);
        @(negedge clk);
        s_din    = cpu_din;
        s_sel    = sel;
        s_busy   = bus_busy;
        s_toggle = obj_toggle;
        release_bus();
    endtask

    task automatic write_io(input logic [23:0] a, input logic [7:0] d);
        bus_access(make_bus(a, 1'b0, 2'b00, 3'd5, {8'h00, d}), 8'd1 << REG_IO);
    endtask

    task automatic read_io(input logic [23:0] a);
        bus_access(make_bus(a, 1'b1, 2'b00, 3'd5, 16'h0000), 8'd1 << REG_IO);
    endtask

    task automatic test_decode();
        int          r;
        int          v;
        chip_sel_t   e;
        logic [23:0] a;
        for (r = 0; r < 6; r++) begin
            for (v = 0; v < 16; v++) begin
                a = {5'd0, v[0], v[0], v[1], 16'h0000};  // Bank bits and scroll half
                bus_access(make_bus(a, 1'b1, v[2] ? 2'b10 : 2'b11, v[3] ? IACK_FC : 3'd6,
                                    16'h0000), 8'd1 << r);
                e = expect_sel(r[2:0], v[0], v[1], v[2], v[3]);
                compare_val("decode", {8'h00, e}, {8'h00, s_sel});
            end
        end
        report_test("decode");
    endtask

    task automatic test_read();
        int   lat;
        logic found;
        bus_access(make_bus(24'h000100, 1'b1, 2'b00, 3'd6, 16'h0), 8'd1 << REG_MEM);
        compare_val("read rom", rom_data, s_din);
        bus_access(make_bus(24'h060100, 1'b1, 2'b00, 3'd6, 16'h0), 8'd1 << REG_MEM);
        compare_val("read ram", ram_data, s_din);
        bus_access(make_bus(24'h010000, 1'b1, 2'b00, 3'd6, 16'h0), 8'd1 << REG_SCR);
        compare_val("read chr", char_dout, s_din);
        bus_access(make_bus(24'h000000, 1'b1, 2'b00, 3'd6, 16'h0), 8'd1 << REG_SCR);
        compare_val("read vram", ram_data, s_din);
        bus_access(make_bus(24'h000000, 1'b1, 2'b00, 3'd6, 16'h0), 8'd1 << REG_PAL);
        compare_val("read pal", pal_dout, s_din);
        bus_access(make_bus(24'h000000, 1'b1, 2'b00, 3'd6, 16'h0), 8'd1 << REG_OBJ);
        compare_val("read objram", obj_dout, s_din);
        bus_access(make_bus(24'h000000, 1'b1, 2'b00, 3'd6, 16'h0), 8'd1 << REG_SUB);
        compare_val("read sub", sub_din, s_din);
        bus_access(make_bus(24'h000000, 1'b1, 2'b00, 3'd6, 16'h0), 8'h00);
        compare_val("read open bus", OPEN_BUS, s_din);
        read_io(24'h000014);
        compare_val("read io", {IO_IDLE, cab.dipsw_a}, s_din);
        compare_val("read io high byte", 16'h00ff, {8'h00, s_din[15:8]});
        // Count clocks until ROM data reaches the CPU
        @(posedge clk);
        bus    <= make_bus(24'h000200, 1'b1, 2'b00, 3'd6, 16'h0);
        active <= 8'd1 << REG_MEM;
        lat   = 0;
        found = 1'b0;
        while (!found && lat < 10) begin
            @(posedge clk);
            @(negedge clk);
            lat++;
            found = (cpu_din === rom_data);
        end
        if (!found) begin
            $display("read latency test timed out waiting for ROM data on cpu_din");
            errors++;
            test_errs++;
        end else begin
            compare_val("read latency", 16'd2, 16'(lat));
        end
        release_bus();
        report_test("read");
    endtask

    task automatic test_outrun();
        compare_val("outrun reset video_en", 16'd1, {15'd0, video_en});
        compare_val("outrun reset snd_rstb", 16'd1, {15'd0, snd_rstb});
        compare_val("outrun reset obj_cfg", 16'd0, {14'd0, obj_cfg});
        write_io(24'h000004, 8'h84);                  // Port C
        compare_val("outrun obj_cfg", 16'd2, {14'd0, obj_cfg});
        compare_val("outrun video_en", 16'd0, {15'd0, video_en});
        compare_val("outrun snd_rstb", 16'd0, {15'd0, snd_rstb});
        write_io(24'h000004, 8'h61);
        compare_val("outrun obj_cfg", 16'd1, {14'd0, obj_cfg});
        compare_val("outrun video_en", 16'd1, {15'd0, video_en});
        compare_val("outrun snd_rstb", 16'd1, {15'd0, snd_rstb});
        read_io(24'h000000);
        compare_val("outrun ppi read", 16'hffff, s_din);
        read_io(24'h000010);
        compare_val("outrun switches", {8'hff, cab.coin_input, ~cab.joystick1[7],
                    cab.joystick1[6], cab.start_button[0], cab.service, cab.dip_test, 1'b1},
                    s_din);
        read_io(24'h000012);
        compare_val("outrun idle port", 16'hffff, s_din);
        read_io(24'h000014);
        compare_val("outrun dip a", {8'hff, cab.dipsw_a}, s_din);
        read_io(24'h000016);
        compare_val("outrun dip b", {8'hff, cab.dipsw_b}, s_din);
        read_io(24'h000070);
        compare_val("outrun obj_toggle", 16'd1, {15'd0, s_toggle});
        compare_val("outrun obj_toggle idle", 16'd0, {15'd0, obj_toggle});
        report_test("outrun");
    endtask

    task automatic test_hangon();
        @(posedge clk);
        game_id <= GAME_SHANGON;
        write_io(24'h000000, 8'h00);
        compare_val("hangon video_en off", 16'd0, {15'd0, video_en});
        write_io(24'h000000, 8'h10);
        compare_val("hangon video_en on", 16'd1, {15'd0, video_en});
        write_io(24'h000020, 8'h01);                  // Sound reset is inverted
        compare_val("hangon snd_rstb low", 16'd0, {15'd0, snd_rstb});
        write_io(24'h000020, 8'h00);
        compare_val("hangon snd_rstb high", 16'd1, {15'd0, snd_rstb});
        read_io(24'h001004);
        compare_val("hangon dip a", {8'hff, cab.dipsw_a}, s_din);
        read_io(24'h001006);
        compare_val("hangon dip b", {8'hff, cab.dipsw_b}, s_din);
        report_test("hangon");
    endtask

    task automatic test_adc();
        int          g;
        int          t;
        int          c;
        int          k;
        logic [23:0] adc_addr;
        logic [15:0] ana1;
        logic [15:0] ana1b;
        logic [7:0]  joy;
        logic [7:0]  expv;
        for (g = 0; g < 2; g++) begin
            @(posedge clk);
            game_id  <= game_e'(g[1:0]);
            adc_addr = (g == 0) ? 24'h000030 : 24'h003020;
            for (t = 0; t < 3; t++) begin
                for (c = 0; c < 4; c++) begin
                    for (k = 0; k < 3; k++) begin
                        joy = (k == 0) ? 8'hff : ((k == 1) ? 8'h00 : 8'hfd);  // Key sets
                        if (g == 0)
                            write_io(24'h000004, {2'b00, 1'b1, c[2:0], 2'b01});
                        else
                            write_io(24'h000000, {c[1:0], 2'b01, 4'h0});
                        ana1  = lcg_next();
                        ana1b = lcg_next();
                        @(posedge clk);
                        cab.joyana1   <= ana1;
                        cab.joyana1b  <= ana1b;
                        cab.joystick1 <= joy;
                        cab.ctrl_type <= ctrl_type_e'(t[2:0]);
                        write_io(adc_addr, 8'h00);    // Capture
                        @(posedge clk);
                        cab.joyana1  <= lcg_next();   // Must not reach the read
                        cab.joyana1b <= lcg_next();
                        read_io(adc_addr);
                        expv = adc_expect(g == 1, t == 1, c[1:0], joy, ana1, ana1b);
                        compare_val("adc", {8'hff, expv}, s_din);
                    end
                end
            end
        end
        report_test("adc");
    endtask

    // ok bits are {rom_ok, ram_ok, sub_ok}
    task automatic busy_case(input string name, input logic [23:0] a, input int r,
                             input logic [2:0] ok, input logic expected);
        @(posedge clk);
        rom_ok <= ok[2];
        ram_ok <= ok[1];
        sub_ok <= ok[0];
        bus_access(make_bus(a, 1'b1, 2'b00, 3'd6, 16'h0), 8'd1 << r);
        compare_val(name, {15'd0, expected}, {15'd0, s_busy});
    endtask

    task automatic test_busy();
        busy_case("busy rom wait", 24'h000000, REG_MEM, 3'b011, 1'b1);
        busy_case("busy rom ready", 24'h000000, REG_MEM, 3'b111, 1'b0);
        busy_case("busy ram wait", 24'h060000, REG_MEM, 3'b101, 1'b1);
        busy_case("busy ram ready", 24'h060000, REG_MEM, 3'b111, 1'b0);
        busy_case("busy vram wait", 24'h000000, REG_SCR, 3'b101, 1'b1);
        busy_case("busy sub wait", 24'h000000, REG_SUB, 3'b110, 1'b1);
        busy_case("busy sub ready", 24'h000000, REG_SUB, 3'b111, 1'b0);
        busy_case("busy pal", 24'h000000, REG_PAL, 3'b000, 1'b0);
        busy_case("busy chr", 24'h010000, REG_SCR, 3'b000, 1'b0);
        @(posedge clk);
        rom_ok <= 1'b1;
        ram_ok <= 1'b1;
        sub_ok <= 1'b1;
        report_test("busy");
    endtask

    initial begin
        rng_state = 32'd45218;
        checks    = 0;
        errors    = 0;
        test_errs = 0;
        rst       = 1'b1;
        bus       = idle_bus();
        active    = 8'h00;
        game_id   = GAME_OUTRUN;
        cab              = '0;
        cab.joystick1    = 8'hff;
        cab.coin_input   = 2'b10;
        cab.start_button = 2'b01;
        cab.dip_test     = 1'b1;
        cab.dipsw_a      = 8'h5a;
        cab.dipsw_b      = 8'hc3;
        cab.ctrl_type    = CTRL_WHEEL;
        rom_data  = 16'h1a01;
        ram_data  = 16'h2b02;
        char_dout = 16'h3c03;
        pal_dout  = 16'h4d04;
        obj_dout  = 16'h5e05;
        sub_din   = 16'h6f06;
        rom_ok    = 1'b1;
        ram_ok    = 1'b1;
        sub_ok    = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_decode();
        test_read();
        test_outrun();
        test_hangon();
        test_adc();
        test_busy();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* sim.f */
main_pkg.sv
mem_decoder.sv
cabinet_io.sv
read_data_mux.sv
main_bus.sv
tb_main_bus.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_main_bus
RTL_TOP   = main_bus
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) || (echo "simulation reported failure"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
